// File: hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int opcodeWidth = 16;
    localparam int flagCount = 4;

    typedef enum logic [5:0] {
        START    = 6'd0,
        FETCH    = 6'd1,
        ATYPE    = 6'd2,
        ITYPE    = 6'd3,
        JTYPE    = 6'd4,
        SITYPE   = 6'd5,
        JFGINSTR = 6'd6,  // Taken flag jump
        RIMMED   = 6'd20, // Operand read at PC
        RADDRESS = 6'd21, // Operand read at A
        HALT     = 6'd63  // Absorbing stop state
    } cpuState_t;

    typedef enum logic [2:0] {
        classA,
        classI,
        classJ,
        classSi,
        classFlagJump, // Condition true
        classFlagSet,  // Flag set or clear
        classNop,      // Condition false
        classInvalid
    } instrClass_t;

    typedef enum logic [2:0] {
        destNone = 3'd0,
        destA    = 3'd1,
        destB    = 3'd2,
        destC    = 3'd3,
        destAdr  = 3'd4, // Memory at address in A
        destAbs  = 3'd5,
        destAbsi = 3'd6
    } dest_t;

    typedef enum logic [2:0] {
        srcReg0 = 3'd0,
        srcReg1 = 3'd1,
        srcReg2 = 3'd2,
        srcReg3 = 3'd3,
        srcImm  = 3'd4,
        srcAbs  = 3'd5,
        srcAddr = 3'd6,
        srcIdx  = 3'd7
    } srcMode_t;

    typedef logic [3:0] aluASel_t; // 0..3 pick a register
    localparam aluASel_t aluAFromPc = 4'd4;
    localparam aluASel_t aluAFromMem = 4'd5;

    typedef logic [3:0] aluBSel_t; // 0..3 pick a register
    localparam aluBSel_t aluBFromOne = 4'd4;
    localparam aluBSel_t aluBFromOp = 4'd5;
    localparam aluBSel_t aluBFromAddr = 4'd6;
    localparam aluBSel_t aluBFromZero = 4'd7;

    typedef enum logic [1:0] {
        memFromPc = 2'd0,
        memFromA  = 2'd1
    } memAddrSel_t;

    typedef logic [3:0] aluFunc_t;
    localparam aluFunc_t aluAdd = 4'd0;
    localparam aluFunc_t aluJump = 4'd6;

    typedef logic [flagCount-1:0] flags_t;

    typedef struct packed {
        instrClass_t instrClass;
        srcMode_t    srcMode;
        dest_t       dest;
        aluFunc_t    aluFunc;
        aluBSel_t    aluB;
        logic [1:0]  flagIndex; // Flag tested or written
        logic        flagValue; // Compare value or new value
    } decodedInstr_t;

    typedef struct packed {
        memAddrSel_t memAddr;
        logic        enPC;
        logic        saveOpcode;
        logic        saveMem1;
        aluFunc_t    aluFunc;
        aluASel_t    aluA;
        aluBSel_t    aluB;
        logic        enA;
        logic        enB;
        logic        enC;
        logic        we;
        logic        re;
        logic        writeFromAlu;
        logic        enF;
        logic        sourceF;   // Flags loaded from inF
        flags_t      inF;
    } ctrlWord_t;

endpackage

`default_nettype wire

// File: hw/opcodeDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module opcodeDecoder (
    input wire [cpuPkg::opcodeWidth-1:0] opcode, // Current instruction
    input wire cpuPkg::flags_t flags,
    output cpuPkg::decodedInstr_t decoded
);

    logic [3:0] top;      // Class bits
    logic       condTrue; // F type condition met

    assign top = opcode[15:12];
    assign condTrue = (flags[opcode[9:8]] == opcode[10]);

    always_comb begin
        // Fields shared by every class
        decoded.srcMode = cpuPkg::srcMode_t'(opcode[11:9]);
        decoded.flagIndex = opcode[9:8];
        decoded.flagValue = opcode[10];

        decoded.instrClass = cpuPkg::classInvalid;
        decoded.dest = cpuPkg::destNone;
        decoded.aluFunc = cpuPkg::aluAdd;
        decoded.aluB = cpuPkg::aluBFromOp;

        if (top == 4'b0000) begin
            decoded.instrClass = cpuPkg::classA;
            decoded.dest = cpuPkg::dest_t'(opcode[2:0]);
            decoded.aluFunc = opcode[8:5];
            decoded.aluB = {2'b00, opcode[4:3]}; // Register operand
        end else if (top[3:2] == 2'b01) begin
            decoded.instrClass = cpuPkg::classI;
            decoded.dest = cpuPkg::dest_t'(opcode[11:9]); // Source doubles as destination
            decoded.aluFunc = {opcode[8], opcode[8], opcode[13:12]};
        end else if (top[3]) begin
            decoded.instrClass = cpuPkg::classJ;
            decoded.aluFunc = cpuPkg::aluJump;
            decoded.aluB = cpuPkg::aluBFromAddr;
        end else if (top == 4'b0001) begin
            decoded.instrClass = cpuPkg::classSi;
            decoded.dest = cpuPkg::dest_t'(opcode[6:4]);
            decoded.aluFunc = {2'b10, opcode[8:7]};
        end else if (top == 4'b0010) begin
            if (opcode[11]) begin
                decoded.instrClass = cpuPkg::classFlagSet;
            end else if (condTrue) begin
                decoded.instrClass = cpuPkg::classFlagJump;
            end else begin
                decoded.instrClass = cpuPkg::classNop; // Not taken
            end
        end
        // Stack class and anything else stays invalid
    end

endmodule

`default_nettype wire

// File: hw/cpuSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module cpuSequencer (
    input wire clk,
    input wire rst,
    input wire stall,
    input wire cpuPkg::decodedInstr_t decoded,
    output cpuPkg::cpuState_t state
);

    cpuPkg::cpuState_t nextState;
    cpuPkg::cpuState_t execState; // Main state of the decoded class
    logic              readsSrc;  // Class has a source operand

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cpuPkg::START;
        end else if (!stall) begin
            state <= nextState;
        end
    end

    always_comb begin
        case (decoded.instrClass)
            cpuPkg::classA:        execState = cpuPkg::ATYPE;
            cpuPkg::classI:        execState = cpuPkg::ITYPE;
            cpuPkg::classSi:       execState = cpuPkg::SITYPE;
            cpuPkg::classJ:        execState = cpuPkg::JTYPE;
            cpuPkg::classFlagJump: execState = cpuPkg::JFGINSTR;
            cpuPkg::classFlagSet,
            cpuPkg::classNop:      execState = cpuPkg::FETCH; // Done inside FETCH
            default:               execState = cpuPkg::HALT;
        endcase
    end

    assign readsSrc = (decoded.instrClass == cpuPkg::classA) ||
                      (decoded.instrClass == cpuPkg::classI) ||
                      (decoded.instrClass == cpuPkg::classSi);

    always_comb begin
        nextState = cpuPkg::HALT;
        case (state)
            cpuPkg::START: nextState = cpuPkg::FETCH;
            cpuPkg::FETCH: begin
                nextState = execState;
                if (readsSrc) begin
                    case (decoded.srcMode)
                        cpuPkg::srcImm:  nextState = cpuPkg::RIMMED;
                        cpuPkg::srcAddr: nextState = cpuPkg::RADDRESS;
                        cpuPkg::srcAbs,
                        cpuPkg::srcIdx:  nextState = cpuPkg::HALT; // Modes not supported
                        default:         nextState = execState;
                    endcase
                end
            end
            cpuPkg::RIMMED, cpuPkg::RADDRESS: nextState = execState;
            cpuPkg::ATYPE, cpuPkg::ITYPE, cpuPkg::SITYPE: begin
                if (decoded.dest == cpuPkg::destAbs || decoded.dest == cpuPkg::destAbsi) begin
                    nextState = cpuPkg::HALT;
                end else begin
                    nextState = cpuPkg::FETCH;
                end
            end
            cpuPkg::JTYPE, cpuPkg::JFGINSTR: nextState = cpuPkg::FETCH;
            default: nextState = cpuPkg::HALT; // HALT holds until reset
        endcase
    end

endmodule

`default_nettype wire

// File: hw/controlWordGen.sv
`timescale 1ns/100ps
`default_nettype none

module controlWordGen (
    input wire cpuPkg::cpuState_t state,
    input wire cpuPkg::decodedInstr_t decoded,
    input wire cpuPkg::flags_t flags, // Current flag register
    output cpuPkg::ctrlWord_t ctrl
);

    cpuPkg::flags_t   flagMask; // One-hot selected flag
    cpuPkg::flags_t   newFlags; // Flags after set or clear
    cpuPkg::aluASel_t srcSel;   // ALU A for the source field

    assign flagMask = cpuPkg::flags_t'(1) << decoded.flagIndex;
    assign newFlags = decoded.flagValue ? (flags | flagMask) : (flags & ~flagMask);

    // Register number, or the operand latched in mem1
    assign srcSel = decoded.srcMode[2] ? cpuPkg::aluAFromMem
                                       : {2'b00, decoded.srcMode[1:0]};

    always_comb begin
        ctrl = '0; // Unused strobes stay low
        case (state)
            cpuPkg::FETCH, cpuPkg::RIMMED: begin
                ctrl.memAddr = cpuPkg::memFromPc; // Read word at PC
                ctrl.re = 1'b1;
                ctrl.aluFunc = cpuPkg::aluAdd;    // PC + 1
                ctrl.aluA = cpuPkg::aluAFromPc;
                ctrl.aluB = cpuPkg::aluBFromOne;
                ctrl.enPC = 1'b1;
                if (state == cpuPkg::FETCH) begin
                    ctrl.saveOpcode = 1'b1;
                    if (decoded.instrClass == cpuPkg::classFlagSet) begin
                        ctrl.enF = 1'b1;
                        ctrl.sourceF = 1'b1;
                        ctrl.inF = newFlags;
                    end
                end else begin
                    ctrl.saveMem1 = 1'b1; // Immediate operand
                end
            end

            cpuPkg::RADDRESS: begin
                ctrl.memAddr = cpuPkg::memFromA; // Operand at address in A
                ctrl.saveMem1 = 1'b1;
                ctrl.re = 1'b1;
            end

            cpuPkg::ATYPE, cpuPkg::ITYPE, cpuPkg::SITYPE: begin
                ctrl.aluA = srcSel;
                ctrl.aluB = decoded.aluB;
                ctrl.aluFunc = decoded.aluFunc;
                ctrl.enF = 1'b1; // Update flags
                case (decoded.dest)
                    cpuPkg::destA: ctrl.enA = 1'b1;
                    cpuPkg::destB: ctrl.enB = 1'b1;
                    cpuPkg::destC: ctrl.enC = 1'b1;
                    cpuPkg::destAdr: begin
                        ctrl.we = 1'b1;
                        ctrl.writeFromAlu = 1'b1;
                        ctrl.memAddr = cpuPkg::memFromA;
                    end
                    default: ; // No register written
                endcase
            end

            cpuPkg::JTYPE: begin
                ctrl.aluA = cpuPkg::aluAFromPc;   // Sign from PC
                ctrl.aluB = cpuPkg::aluBFromAddr; // Offset from instruction
                ctrl.aluFunc = cpuPkg::aluJump;
                ctrl.enPC = 1'b1;
            end

            cpuPkg::JFGINSTR: begin
                ctrl.aluA = cpuPkg::aluAFromPc;
                ctrl.aluB = cpuPkg::aluBFromOp; // Short offset
                ctrl.aluFunc = cpuPkg::aluAdd;
                ctrl.enPC = 1'b1;
            end

            default: ; // START and HALT keep every strobe low
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpuController.sv
`timescale 1ns/100ps
`default_nettype none

module cpuController (
    input wire clk,
    input wire rst,
    input wire [cpuPkg::opcodeWidth-1:0] opcode, // Instruction register
    input wire cpuPkg::flags_t flags,
    input wire stall,                            // Holds the state register
    output wire cpuPkg::ctrlWord_t ctrl,
    output wire cpuPkg::cpuState_t state
);

    wire cpuPkg::decodedInstr_t decoded;

    opcodeDecoder opcodeDecoder_i (
        .opcode  (opcode),
        .flags   (flags),
        .decoded (decoded)
    );

    cpuSequencer cpuSequencer_i (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .decoded (decoded),
        .state   (state)
    );

    controlWordGen controlWordGen_i (
        .state   (state),
        .decoded (decoded),
        .flags   (flags),
        .ctrl    (ctrl)
    );

endmodule

`default_nettype wire

// File: bench/cpuVectors.svh
`ifndef CPU_VECTORS_SVH
`define CPU_VECTORS_SVH

// Columns: name, opcode, flags, stall, rst, expected state, expected ctrl
// A row with stall set is applied stallRun times with stall held high
task automatic loadVectors();
    // A type, register source then memory destination
    addRow("aRegFetch", 16'h0272, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("aRegExec", 16'h0272, 4'h0, 1'b0, 1'b0, cpuPkg::ATYPE,
           execStrobes(4'd1, 4'd2, 4'd3, cpuPkg::destB));
    addRow("aAdrFetch", 16'h06A4, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("aAdrExec", 16'h06A4, 4'h0, 1'b0, 1'b0, cpuPkg::ATYPE,
           execStrobes(4'd3, 4'd0, 4'd5, cpuPkg::destAdr));
    addRow("iRegFetch", 16'h6500, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("iRegExec", 16'h6500, 4'h0, 1'b0, 1'b0, cpuPkg::ITYPE,
           execStrobes(4'd2, cpuPkg::aluBFromOp, 4'hE, cpuPkg::destB));
    addRow("siRegFetch", 16'h16B0, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("siRegExec", 16'h16B0, 4'h0, 1'b0, 1'b0, cpuPkg::SITYPE,
           execStrobes(4'd3, cpuPkg::aluBFromOp, 4'd9, cpuPkg::destC));

    // Operand fetched before execute
    addRow("aImmFetch", 16'h0829, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("aImmRead", 16'h0829, 4'h0, 1'b0, 1'b0, cpuPkg::RIMMED, immReadStrobes());
    addRow("aImmExec", 16'h0829, 4'h0, 1'b0, 1'b0, cpuPkg::ATYPE,
           execStrobes(cpuPkg::aluAFromMem, 4'd1, 4'd1, cpuPkg::destA));
    addRow("siAddrFetch", 16'h1D10, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("siAddrRead", 16'h1D10, 4'h0, 1'b0, 1'b0, cpuPkg::RADDRESS, addrReadStrobes());
    addRow("siAddrExec", 16'h1D10, 4'h0, 1'b0, 1'b0, cpuPkg::SITYPE,
           execStrobes(cpuPkg::aluAFromMem, cpuPkg::aluBFromOp, 4'hA, cpuPkg::destA));

    // Jumps and flag writes
    addRow("jumpFetch", 16'h8123, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("jumpExec", 16'h8123, 4'h0, 1'b0, 1'b0, cpuPkg::JTYPE, jumpStrobes());
    addRow("fjTrueFetch", 16'h2605, 4'h4, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("fjTrueExec", 16'h2605, 4'h4, 1'b0, 1'b0, cpuPkg::JFGINSTR, flagJumpStrobes());
    addRow("fjFalse", 16'h2605, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("flagSet", 16'h2D00, 4'h8, 1'b0, 1'b0, cpuPkg::FETCH, flagWriteStrobes(4'hA));
    addRow("flagClear", 16'h2B00, 4'h9, 1'b0, 1'b0, cpuPkg::FETCH, flagWriteStrobes(4'h1));

    // I type immediate with a stall inside RIMMED
    addRow("stallFetch", 16'h5800, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("stallHold", 16'h5800, 4'h0, 1'b1, 1'b0, cpuPkg::RIMMED, immReadStrobes());
    addRow("stallResume", 16'h5800, 4'h0, 1'b0, 1'b0, cpuPkg::RIMMED, immReadStrobes());
    addRow("stallExec", 16'h5800, 4'h0, 1'b0, 1'b0, cpuPkg::ITYPE,
           execStrobes(cpuPkg::aluAFromMem, cpuPkg::aluBFromOp, 4'd1, cpuPkg::destAdr));

    // Stop cases, each cleared by a reset
    addRow("absSrcFetch", 16'h0A01, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("absSrcHalt", 16'h0A01, 4'h0, 1'b0, 1'b0, cpuPkg::HALT, noStrobes());
    addRow("absSrcHold", 16'h0272, 4'h0, 1'b0, 1'b0, cpuPkg::HALT, noStrobes());
    addRow("resetA", 16'h0272, 4'h0, 1'b0, 1'b1, cpuPkg::START, noStrobes());
    addRow("releaseA", 16'h005E, 4'h0, 1'b0, 1'b0, cpuPkg::START, noStrobes());
    addRow("idxDestFetch", 16'h005E, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("idxDestExec", 16'h005E, 4'h0, 1'b0, 1'b0, cpuPkg::ATYPE,
           execStrobes(4'd0, 4'd3, 4'd2, cpuPkg::destAbsi));
    addRow("idxDestHalt", 16'h005E, 4'h0, 1'b0, 1'b0, cpuPkg::HALT, noStrobes());
    addRow("resetB", 16'h005E, 4'h0, 1'b0, 1'b1, cpuPkg::START, noStrobes());
    addRow("releaseB", 16'h3000, 4'h0, 1'b0, 1'b0, cpuPkg::START, noStrobes());
    addRow("invalidFetch", 16'h3000, 4'h0, 1'b0, 1'b0, cpuPkg::FETCH, fetchStrobes());
    addRow("invalidHalt", 16'h3000, 4'h0, 1'b0, 1'b0, cpuPkg::HALT, noStrobes());
    addRow("invalidHold", 16'h8123, 4'hF, 1'b0, 1'b0, cpuPkg::HALT, noStrobes());
endtask

`endif

// File: bench/cpuControllerTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuControllerTb;

    logic                           clk;
    logic                           rst;
    logic                           stall;
    logic [cpuPkg::opcodeWidth-1:0] opcode;
    cpuPkg::flags_t                 flags;
    wire cpuPkg::ctrlWord_t         ctrl;
    wire cpuPkg::cpuState_t         state;

    // Table columns, one queue each
    string                          names[$];
    logic [cpuPkg::opcodeWidth-1:0] opcodes[$];
    cpuPkg::flags_t                 flagsIn[$];
    logic                           stalls[$];
    logic                           resets[$];
    cpuPkg::cpuState_t              expStates[$];
    cpuPkg::ctrlWord_t              expCtrls[$];

    int stallRun;       // Length of the stall run
    int cycleLimit = 0; // Watchdog budget

    cpuController cpuController_i (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .flags  (flags),
        .stall  (stall),
        .ctrl   (ctrl),
        .state  (state)
    );

    always #50 clk = ~clk; // 100 ns period

    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
    endfunction

    function automatic void addRow(input string name, input logic [15:0] op,
                                   input cpuPkg::flags_t fl, input logic st, input logic rs,
                                   input cpuPkg::cpuState_t expState,
                                   input cpuPkg::ctrlWord_t expCtrl);
        names.push_back(name);
        opcodes.push_back(op);
        flagsIn.push_back(fl);
        stalls.push_back(st);
        resets.push_back(rs);
        expStates.push_back(expState);
        expCtrls.push_back(expCtrl);
    endfunction

    function automatic cpuPkg::ctrlWord_t noStrobes();
        return '0;
    endfunction

    function automatic cpuPkg::ctrlWord_t fetchStrobes();
        cpuPkg::ctrlWord_t c;
        c = '0;
        c.memAddr = cpuPkg::memFromPc; // Opcode read at PC
        c.re = 1'b1;
        c.saveOpcode = 1'b1;
        c.enPC = 1'b1;
        c.aluFunc = cpuPkg::aluAdd;
        c.aluA = cpuPkg::aluAFromPc;
        c.aluB = cpuPkg::aluBFromOne;
        return c;
    endfunction

    function automatic cpuPkg::ctrlWord_t flagWriteStrobes(input cpuPkg::flags_t newFlags);
        cpuPkg::ctrlWord_t c;
        c = fetchStrobes();
        c.enF = 1'b1;
        c.sourceF = 1'b1;
        c.inF = newFlags;
        return c;
    endfunction

    function automatic cpuPkg::ctrlWord_t immReadStrobes();
        cpuPkg::ctrlWord_t c;
        c = fetchStrobes();
        c.saveOpcode = 1'b0; // Operand goes to mem1
        c.saveMem1 = 1'b1;
        return c;
    endfunction

    function automatic cpuPkg::ctrlWord_t addrReadStrobes();
        cpuPkg::ctrlWord_t c;
        c = '0;
        c.memAddr = cpuPkg::memFromA;
        c.re = 1'b1;
        c.saveMem1 = 1'b1;
        return c;
    endfunction

    function automatic cpuPkg::ctrlWord_t execStrobes(input cpuPkg::aluASel_t aSel,
                                                      input cpuPkg::aluBSel_t bSel,
                                                      input cpuPkg::aluFunc_t func,
                                                      input cpuPkg::dest_t dest);
        cpuPkg::ctrlWord_t c;
        c = '0;
        c.aluA = aSel;
        c.aluB = bSel;
        c.aluFunc = func;
        c.enF = 1'b1;
        c.enA = (dest == cpuPkg::destA);
        c.enB = (dest == cpuPkg::destB);
        c.enC = (dest == cpuPkg::destC);
        if (dest == cpuPkg::destAdr) begin
            c.we = 1'b1; // Result to memory at A
            c.writeFromAlu = 1'b1;
            c.memAddr = cpuPkg::memFromA;
        end
        return c;
    endfunction

    function automatic cpuPkg::ctrlWord_t jumpStrobes();
        cpuPkg::ctrlWord_t c;
        c = '0;
        c.aluA = cpuPkg::aluAFromPc;
        c.aluB = cpuPkg::aluBFromAddr;
        c.aluFunc = cpuPkg::aluJump;
        c.enPC = 1'b1;
        return c;
    endfunction

    function automatic cpuPkg::ctrlWord_t flagJumpStrobes();
        cpuPkg::ctrlWord_t c;
        c = '0;
        c.aluA = cpuPkg::aluAFromPc;
        c.aluB = cpuPkg::aluBFromOp; // Short offset in opcode
        c.aluFunc = cpuPkg::aluAdd;
        c.enPC = 1'b1;
        return c;
    endfunction

    `include "cpuVectors.svh"

    task automatic abortRun(input string reason);
        $display("Simulation failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkState(input string name, input cpuPkg::cpuState_t exp,
                              input cpuPkg::cpuState_t act);
        if (act !== exp) begin
            $display("ERROR %s: state expected %s (%0d), actual %s (%0d)",
                     name, exp.name(), exp, act.name(), act);
            abortRun("State register differs from the table");
        end
    endtask

    task automatic checkCtrl(input string name, input cpuPkg::ctrlWord_t exp,
                             input cpuPkg::ctrlWord_t act);
        if (act !== exp) begin
            $display("ERROR %s: ctrl expected %h, actual %h", name, exp, act);
            abortRun("Control word differs from the table");
        end
    endtask

    task automatic applyRow(input int idx, input logic stallLevel);
        @(posedge clk);
        rst <= resets[idx];
        opcode <= opcodes[idx];
        flags <= flagsIn[idx];
        stall <= stallLevel;
        @(negedge clk); // Outputs settled
        checkState(names[idx], expStates[idx], state);
        checkCtrl(names[idx], expCtrls[idx], ctrl);
    endtask

    initial begin
        wait (cycleLimit > 0);
        #(cycleLimit * 100);
        abortRun($sformatf("Timeout after %0d cycles, the table did not finish", cycleLimit));
    end

    initial begin
        logic [31:0] lfsr;
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        opcode = '0;
        flags = '0;

        lfsr = 32'h6fea;
        stallRun = 2;
        for (int b = 0; b < 3; b++) begin
            lfsr = stepLfsr(lfsr); // One step per bit
            if (lfsr[0]) begin
                stallRun += 1 << b;
            end
        end

        loadVectors();
        cycleLimit = names.size() + stallRun + 20;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkState("reset", cpuPkg::START, state);
        checkCtrl("reset", noStrobes(), ctrl);

        for (int i = 0; i < names.size(); i++) begin
            if (stalls[i]) begin
                repeat (stallRun) begin
                    applyRow(i, 1'b1); // Same state and strobes each cycle
                end
            end else begin
                applyRow(i, 1'b0);
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+bench
hw/cpuPkg.sv
hw/opcodeDecoder.sv
hw/cpuSequencer.sv
hw/controlWordGen.sv
hw/cpuController.sv
bench/cpuControllerTb.sv

// File: Makefile
TOP = cpuControllerTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
